// ==== icache.f ====
source/icache_cfg_pkg.sv
source/icache_bus_pkg.sv
source/icache_sram.sv
source/icache_replace.sv
source/icache_lookup.sv
source/icache_ctrl.sv
source/icache_top.sv
verif/icache_properties.sv
verif/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the icache regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module icache_tb -f icache.f -Mdir obj_dir

out=$(./obj_dir/Vicache_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^Regression passed$"; then
  exit 0
fi
exit 1

// ==== source/icache_bus_pkg.sv ====
// wishbone port structs
`default_nettype none

package icache_bus_pkg;

  ////////////////////////////////////////
  // fetch side, cache is the slave
  ////////////////////////////////////////

  // driven by the fetch master
  typedef struct packed {
    logic                                  cyc;
    logic                                  stb;
    logic [icache_cfg_pkg::ADDR_WIDTH-1:0] adr;
  } fetch_req_t;

  // driven by the cache
  typedef struct packed {
    logic                                   ack;
    logic [icache_cfg_pkg::FETCH_WIDTH-1:0] dat;
  } fetch_rsp_t;

  ////////////////////////////////////////
  // memory side, cache is the master
  ////////////////////////////////////////

  // line aligned for refills, word address for non-cacheable
  typedef struct packed {
    logic                                  cyc;
    logic                                  stb;
    logic [icache_cfg_pkg::ADDR_WIDTH-1:0] adr;
  } mem_req_t;

  // always a full line, sampled in the ack cycle
  typedef struct packed {
    logic                  ack;
    icache_cfg_pkg::line_t dat;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== source/icache_cfg_pkg.sv ====
// instruction cache geometry
`default_nettype none

package icache_cfg_pkg;

  ////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////

  localparam int NUM_WAYS      = 2;
  localparam int NUM_SETS      = 16;
  localparam int LINE_WIDTH    = 128;
  localparam int FETCH_WIDTH   = 32;
  localparam int ADDR_WIDTH    = 32;
  // 16 byte lines
  localparam int OFFSET_WIDTH  = 4;
  localparam int INDEX_WIDTH   = 4;
  localparam int TAG_WIDTH     = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int WAY_IDX_WIDTH = 1;
  // upper half of the address space bypasses the arrays
  localparam int NC_BIT        = 31;

  ////////////////////////////////////////
  // address split and array payloads
  ////////////////////////////////////////

  typedef logic [TAG_WIDTH-1:0]      tag_t;
  typedef logic [INDEX_WIDTH-1:0]    set_idx_t;
  // word position, byte offset without the two alignment bits
  typedef logic [OFFSET_WIDTH-3:0]   word_sel_t;
  typedef logic [LINE_WIDTH-1:0]     line_t;
  typedef logic [NUM_WAYS-1:0]       way_oh_t;

  // one tag array entry
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

endpackage

`default_nettype wire

// ==== source/icache_ctrl.sv ====
// instruction cache controller
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_i,
  input  logic                   flush_i,
  output logic                   miss_o,
  input  fetch_req_t             fetch_req_i,
  output fetch_rsp_t             fetch_rsp_o,
  output mem_req_t               mem_req_o,
  input  mem_rsp_t               mem_rsp_i,
  output logic                   arr_rd_o,
  output logic                   line_we_o,
  output logic                   flush_we_o,
  output set_idx_t               arr_idx_o,
  output tag_t                   tag_o,
  output word_sel_t              word_o,
  output logic                   cmp_en_o,
  input  logic                   hit_i,
  input  logic [FETCH_WIDTH-1:0] hit_data_i
);

  typedef enum logic [1:0] {FLUSH, IDLE, LOOKUP, REFILL} state_e;

  state_e                state_d, state_q;
  logic                  flush_pend_d, flush_pend_q;
  logic                  en_d, en_q;
  set_idx_t              flush_cnt_d, flush_cnt_q;
  logic [ADDR_WIDTH-1:0] adr_q;
  logic                  fetch_req;
  logic                  accept;
  logic                  flush_done;
  logic                  nc;
  logic                  fetch_ack;

  ////////////////////////////////////////
  // address latch and decode
  ////////////////////////////////////////

  assign fetch_req  = fetch_req_i.cyc & fetch_req_i.stb;
  // disabled cache treats everything as non-cacheable
  // en_q only changes in IDLE and FLUSH, so nc is stable per transaction
  assign nc         = adr_q[NC_BIT] | ~en_q;
  assign tag_o      = adr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign word_o     = adr_q[OFFSET_WIDTH-1:2];
  assign flush_done = (flush_cnt_q == set_idx_t'(NUM_SETS - 1));

  // flush walks the sets, IDLE reads with the live address,
  // later states use the latched one for the line write
  always_comb begin
    case (state_q)
      FLUSH:   arr_idx_o = flush_cnt_q;
      IDLE:    arr_idx_o = fetch_req_i.adr[OFFSET_WIDTH +: INDEX_WIDTH];
      default: arr_idx_o = adr_q[OFFSET_WIDTH +: INDEX_WIDTH];
    endcase
  end

  ////////////////////////////////////////
  // wishbone outputs
  ////////////////////////////////////////

  // held for the whole refill until the memory ack
  assign mem_req_o.cyc = (state_q == REFILL);
  assign mem_req_o.stb = (state_q == REFILL);
  assign mem_req_o.adr = nc ? {adr_q[ADDR_WIDTH-1:2], 2'b00}
                            : {adr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

  assign fetch_rsp_o.ack = fetch_ack;
  // hit data in LOOKUP, otherwise the word out of the returned line
  assign fetch_rsp_o.dat = (state_q == LOOKUP) ? hit_data_i
                         : mem_rsp_i.dat[word_o * FETCH_WIDTH +: FETCH_WIDTH];

  ////////////////////////////////////////
  // controller FSM
  ////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    en_d         = en_q;
    // a flush seen during a transaction waits for IDLE
    flush_pend_d = flush_pend_q | flush_i;
    flush_cnt_d  = flush_cnt_q;
    accept       = 1'b0;
    arr_rd_o     = 1'b0;
    line_we_o    = 1'b0;
    flush_we_o   = 1'b0;
    cmp_en_o     = 1'b0;
    fetch_ack    = 1'b0;
    miss_o       = 1'b0;

    case (state_q)
      // clear one set per cycle
      FLUSH: begin
        flush_we_o  = 1'b1;
        flush_cnt_d = flush_cnt_q + 1'b1;
        if (flush_done) begin
          state_d      = IDLE;
          flush_cnt_d  = '0;
          flush_pend_d = 1'b0;
          // enable takes effect only after a clean array
          en_d         = en_i;
        end
      end
      IDLE: begin
        // disabling is always allowed
        en_d = en_q & en_i;
        if (flush_pend_d || (en_i && !en_q)) begin
          state_d = FLUSH;
        end else if (fetch_req) begin
          accept   = 1'b1;
          arr_rd_o = 1'b1;
          state_d  = LOOKUP;
        end
      end
      // arrays are valid now
      LOOKUP: begin
        cmp_en_o = ~nc;
        if (hit_i) begin
          fetch_ack = 1'b1;
          state_d   = IDLE;
        end else begin
          state_d = REFILL;
        end
      end
      // wait for memory, nc data is never written
      REFILL: begin
        if (mem_rsp_i.ack) begin
          fetch_ack = 1'b1;
          line_we_o = ~nc;
          miss_o    = ~nc;
          state_d   = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      en_q         <= 1'b0;
      flush_pend_q <= 1'b0;
      flush_cnt_q  <= '0;
    end else begin
      state_q      <= state_d;
      en_q         <= en_d;
      flush_pend_q <= flush_pend_d;
      flush_cnt_q  <= flush_cnt_d;
    end
  end

  // fetch address, captured when the request is taken
  always_ff @(posedge clk_i) begin
    if (accept) begin
      adr_q <= fetch_req_i.adr;
    end
  end

endmodule

`default_nettype wire

// ==== source/icache_lookup.sv ====
// tag compare and hit word select
`timescale 1ns/1ps
`default_nettype none

module icache_lookup
  import icache_cfg_pkg::*;
(
  input  tag_t                   tag_i,
  input  word_sel_t              word_i,
  input  logic                   cmp_en_i,
  input  tag_entry_t             tags_i [NUM_WAYS],
  input  line_t                  lines_i [NUM_WAYS],
  output logic                   hit_o,
  output logic [FETCH_WIDTH-1:0] hit_data_o,
  output way_oh_t                valid_o
);

  way_oh_t                  hit_vec;
  logic [WAY_IDX_WIDTH-1:0] hit_idx;
  logic [FETCH_WIDTH-1:0]   way_words [NUM_WAYS];

  ////////////////////////////////////////
  // per-way compare
  ////////////////////////////////////////

  for (genvar i = 0; i < NUM_WAYS; i++) begin : gen_way
    // valid bits feed the replacement logic
    assign valid_o[i]   = tags_i[i].valid;
    // no hit at all outside a cacheable lookup
    assign hit_vec[i]   = cmp_en_i & tags_i[i].valid & (tags_i[i].tag == tag_i);
    // addressed word of this way
    assign way_words[i] = lines_i[i][word_i * FETCH_WIDTH +: FETCH_WIDTH];
  end

  ////////////////////////////////////////
  // hit way encoding
  ////////////////////////////////////////

  // lowest hitting way
  // at most one way should hit, the order only matters on a fault
  always_comb begin
    hit_idx = '0;
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (hit_vec[i]) begin
        hit_idx = WAY_IDX_WIDTH'(i);
      end
    end
  end

  assign hit_o      = |hit_vec;
  // only meaningful together with hit_o
  assign hit_data_o = way_words[hit_idx];

endmodule

`default_nettype wire

// ==== source/icache_replace.sv ====
// victim way selection
`timescale 1ns/1ps
`default_nettype none

module icache_replace
  import icache_cfg_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  way_oh_t valid_i,
  input  logic    cmp_en_i,
  input  logic    line_we_i,
  output way_oh_t victim_oh_o
);

  logic [7:0]               lfsr_q;
  logic                     lfsr_fb;
  logic                     all_valid;
  logic [WAY_IDX_WIDTH-1:0] inv_idx;
  logic [WAY_IDX_WIDTH-1:0] victim_idx;

  assign all_valid = &valid_i;

  // lowest invalid way, scanned from the top so the last match wins
  always_comb begin
    inv_idx = '0;
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (!valid_i[i]) begin
        inv_idx = WAY_IDX_WIDTH'(i);
      end
    end
  end

  // random choice only once the set is full
  assign victim_idx = all_valid ? lfsr_q[WAY_IDX_WIDTH-1:0] : inv_idx;

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  // advance on every replacement of a valid line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'h5a;
    end else if (line_we_i && all_valid) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
    end
  end

  // victim is captured in the lookup cycle and used at the line write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      victim_oh_o <= '0;
    end else if (cmp_en_i) begin
      victim_oh_o <= way_oh_t'(1) << victim_idx;
    end
  end

endmodule

`default_nettype wire

// ==== source/icache_sram.sv ====
// single-port cache array
`timescale 1ns/1ps
`default_nettype none

module icache_sram
  import icache_cfg_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     req_i,
  input  logic     we_i,
  input  set_idx_t addr_i,
  input  payload_t wdata_i,
  output payload_t rdata_o
);

  // one entry per set
  payload_t mem_q [NUM_SETS];

  // write port
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // read data one cycle after the request
  // output holds its value while the array is idle or written
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== source/icache_top.sv ====
// two-way instruction cache top
`timescale 1ns/1ps
`default_nettype none

module icache_top
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       en_i,
  input  logic       flush_i,
  output logic       miss_o,
  input  fetch_req_t fetch_req_i,
  output fetch_rsp_t fetch_rsp_o,
  output mem_req_t   mem_req_o,
  input  mem_rsp_t   mem_rsp_i
);

  logic                   arr_rd;
  logic                   line_we;
  logic                   flush_we;
  logic                   cmp_en;
  logic                   hit;
  logic [FETCH_WIDTH-1:0] hit_data;
  set_idx_t               arr_idx;
  tag_t                   cur_tag;
  word_sel_t              cur_word;
  way_oh_t                valid;
  way_oh_t                victim_oh;
  tag_entry_t             tag_wdata;
  tag_entry_t             tag_rd [NUM_WAYS];
  line_t                  line_rd [NUM_WAYS];

  icache_ctrl u_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .en_i        ( en_i        ),
    .flush_i     ( flush_i     ),
    .miss_o      ( miss_o      ),
    .fetch_req_i ( fetch_req_i ),
    .fetch_rsp_o ( fetch_rsp_o ),
    .mem_req_o   ( mem_req_o   ),
    .mem_rsp_i   ( mem_rsp_i   ),
    .arr_rd_o    ( arr_rd      ),
    .line_we_o   ( line_we     ),
    .flush_we_o  ( flush_we    ),
    .arr_idx_o   ( arr_idx     ),
    .tag_o       ( cur_tag     ),
    .word_o      ( cur_word    ),
    .cmp_en_o    ( cmp_en      ),
    .hit_i       ( hit         ),
    .hit_data_i  ( hit_data    )
  );

  icache_lookup u_lookup (
    .tag_i      ( cur_tag  ),
    .word_i     ( cur_word ),
    .cmp_en_i   ( cmp_en   ),
    .tags_i     ( tag_rd   ),
    .lines_i    ( line_rd  ),
    .hit_o      ( hit      ),
    .hit_data_o ( hit_data ),
    .valid_o    ( valid    )
  );

  icache_replace u_replace (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .valid_i     ( valid     ),
    .cmp_en_i    ( cmp_en    ),
    .line_we_i   ( line_we   ),
    .victim_oh_o ( victim_oh )
  );

  // flush writes an invalid entry, a refill a valid one
  assign tag_wdata = '{valid: ~flush_we, tag: cur_tag};

  ////////////////////////////////////////
  // per-way tag and data arrays
  ////////////////////////////////////////

  for (genvar i = 0; i < NUM_WAYS; i++) begin : gen_way
    logic way_wr;

    // refill writes only the victim way
    assign way_wr = line_we & victim_oh[i];

    icache_sram #(.payload_t(tag_entry_t)) u_tag_sram (
      .clk_i   ( clk_i                      ),
      .req_i   ( arr_rd | flush_we | way_wr ),
      .we_i    ( flush_we | way_wr          ),
      .addr_i  ( arr_idx                    ),
      .wdata_i ( tag_wdata                  ),
      .rdata_o ( tag_rd[i]                  )
    );

    icache_sram #(.payload_t(line_t)) u_data_sram (
      .clk_i   ( clk_i           ),
      .req_i   ( arr_rd | way_wr ),
      .we_i    ( way_wr          ),
      .addr_i  ( arr_idx         ),
      .wdata_i ( mem_rsp_i.dat   ),
      .rdata_o ( line_rd[i]      )
    );
  end

endmodule

`default_nettype wire

// ==== verif/icache_properties.sv ====
// cache handshake assertions
`timescale 1ns/1ps
`default_nettype none

module icache_properties
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input logic       miss_i,
  input fetch_rsp_t fetch_rsp_i,
  input mem_req_t   mem_req_i,
  input mem_rsp_t   mem_rsp_i,
  input way_oh_t    hit_vec_i
);

  // master holds stb and adr until memory acks
  mem_stb_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i.stb && !mem_rsp_i.ack |=> mem_req_i.stb && $stable(mem_req_i.adr))
    else $error("memory stb or adr changed before ack");

  // single cycle fetch ack
  fetch_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_rsp_i.ack |=> !fetch_rsp_i.ack)
    else $error("fetch ack longer than one cycle");

  // a line lives in one way at most
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_vec_i))
    else $error("more than one way hit");

  // miss is reported at the ack of a cacheable refill only
  miss_at_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss_i |-> mem_rsp_i.ack && mem_req_i.stb && !mem_req_i.adr[NC_BIT])
    else $error("miss outside a cacheable refill ack");

endmodule

`default_nettype wire

// ==== verif/icache_tb.sv ====
// instruction cache testbench
`timescale 1ns/1ps
`default_nettype none

module icache_tb
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
();

  localparam logic [1:0] MEM_NO      = 2'd0;
  localparam logic [1:0] MEM_YES     = 2'd1;
  localparam logic [1:0] MEM_ANY     = 2'd2;
  localparam int         NUM_STIM    = 18;
  localparam int         ACK_TIMEOUT = 100;

  typedef struct packed {
    logic [3:0]  test;
    logic [31:0] adr;
    logic        en;
    logic        flush;
    logic [1:0]  mem;
  } stim_t;

  // test, fetch address, en_i, flush before fetch, memory access expected
  localparam stim_t STIM_TABLE [NUM_STIM] = '{
    '{4'd2, 32'h0000_1230, 1'b1, 1'b0, MEM_YES},
    '{4'd2, 32'h0000_1238, 1'b1, 1'b0, MEM_NO},
    '{4'd3, 32'h8000_0454, 1'b1, 1'b0, MEM_YES},
    '{4'd3, 32'h8000_0454, 1'b1, 1'b0, MEM_YES},
    '{4'd3, 32'h8000_0458, 1'b1, 1'b0, MEM_YES},
    '{4'd4, 32'h0000_2340, 1'b1, 1'b0, MEM_YES},
    '{4'd4, 32'h0000_2344, 1'b1, 1'b0, MEM_NO},
    '{4'd4, 32'h0000_2348, 1'b1, 1'b1, MEM_YES},
    // three tags in set 5
    '{4'd5, 32'h0000_3050, 1'b1, 1'b0, MEM_ANY},
    '{4'd5, 32'h0000_4054, 1'b1, 1'b0, MEM_ANY},
    '{4'd5, 32'h0000_5058, 1'b1, 1'b0, MEM_ANY},
    '{4'd5, 32'h0000_305c, 1'b1, 1'b0, MEM_ANY},
    '{4'd5, 32'h0000_4050, 1'b1, 1'b0, MEM_ANY},
    '{4'd5, 32'h0000_5054, 1'b1, 1'b0, MEM_ANY},
    '{4'd6, 32'h0000_2340, 1'b0, 1'b0, MEM_YES},
    '{4'd6, 32'h0000_2344, 1'b0, 1'b0, MEM_YES},
    '{4'd6, 32'h0000_2348, 1'b1, 1'b0, MEM_YES},
    '{4'd6, 32'h0000_234c, 1'b1, 1'b0, MEM_NO}
  };

  logic       clk = 1'b0;
  logic       rst_n;
  logic       en;
  logic       flush;
  logic       miss;
  fetch_req_t fetch_req;
  fetch_rsp_t fetch_rsp;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp = '0;

  // memory responder state
  integer      seed = 32'h8efa6d92;
  int          rnd;
  int          mem_wait;
  int          mem_reqs = 0;
  bit          mem_busy;
  logic [31:0] mem_adr_seen;

  always #10 clk = ~clk;

  icache_top dut0 (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .en_i        ( en        ),
    .flush_i     ( flush     ),
    .miss_o      ( miss      ),
    .fetch_req_i ( fetch_req ),
    .fetch_rsp_o ( fetch_rsp ),
    .mem_req_o   ( mem_req   ),
    .mem_rsp_i   ( mem_rsp   )
  );

  bind icache_top icache_properties props0 (
    .clk_i       ( clk_i            ),
    .rst_ni      ( rst_ni           ),
    .miss_i      ( miss_o           ),
    .fetch_rsp_i ( fetch_rsp_o      ),
    .mem_req_i   ( mem_req_o        ),
    .mem_rsp_i   ( mem_rsp_i        ),
    .hit_vec_i   ( u_lookup.hit_vec )
  );

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  // address in the upper half, its inverse in the lower half
  function automatic logic [31:0] word_at(input logic [31:0] a);
    return {a[15:0], ~a[15:0]};
  endfunction

  // whole line around adr, word 0 in the low bits
  function automatic line_t line_at(input logic [31:0] adr);
    line_t       line;
    logic [31:0] a;
    for (int i = 0; i < LINE_WIDTH / FETCH_WIDTH; i++) begin
      a = {adr[31:4], 4'b0000} + 32'(i * 4);
      line[i*FETCH_WIDTH +: FETCH_WIDTH] = word_at(a);
    end
    return line;
  endfunction

  // random latency of 1 to 4 cycles per request
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_rsp  <= '0;
      mem_busy = 1'b0;
      mem_wait = 0;
    end else if (mem_rsp.ack) begin
      mem_rsp.ack <= 1'b0;
      mem_busy    = 1'b0;
    end else if (mem_req.cyc && mem_req.stb) begin
      if (!mem_busy) begin
        mem_busy     = 1'b1;
        rnd          = $random(seed);
        mem_wait     = 1 + (rnd & 3);
        mem_reqs     = mem_reqs + 1;
        mem_adr_seen = mem_req.adr;
      end
      mem_wait = mem_wait - 1;
      if (mem_wait == 0) begin
        mem_rsp.ack <= 1'b1;
        mem_rsp.dat <= line_at(mem_req.adr);
      end
    end
  end

  ////////////////////////////////////////
  // fetch master
  ////////////////////////////////////////

  // one fetch, optional flush pulse first, stb held until ack
  task automatic run_fetch(input stim_t s, output bit acked, output int cycles,
                           output int misses, output logic [31:0] data);
    acked  = 1'b0;
    cycles = 0;
    misses = 0;
    data   = '0;
    @(posedge clk);
    en <= s.en;
    if (s.flush) begin
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
    end
    fetch_req <= '{cyc: 1'b1, stb: 1'b1, adr: s.adr};
    while (!acked && cycles < ACK_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (miss) misses++;
      if (fetch_rsp.ack) begin
        acked = 1'b1;
        data  = fetch_rsp.dat;
      end
    end
    fetch_req <= '0;
  endtask

  initial begin
    stim_t       s;
    bit          acked;
    bit          timed_out;
    bit          exp_miss;
    int          cycles;
    int          misses;
    int          new_reqs;
    int          reqs_before;
    int          errors;
    int          test_errors;
    int          test_hits;
    int          tests_run;
    int          tests_failed;
    logic [31:0] rdata;
    logic [31:0] exp_word;
    logic [31:0] exp_adr;

    rst_n        = 1'b0;
    en           = 1'b0;
    flush        = 1'b0;
    fetch_req    = '0;
    timed_out    = 1'b0;
    errors       = 0;
    test_errors  = 0;
    test_hits    = 0;
    tests_run    = 0;
    tests_failed = 0;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // quiet outputs before any request, cache still off
    repeat (8) begin
      @(posedge clk);
      if (fetch_rsp.ack || mem_req.cyc || mem_req.stb || miss) begin
        $display("MISMATCH {fetch_rsp_o.ack,mem_req_o.cyc,mem_req_o.stb,miss_o}: got %h expected 0",
                 {fetch_rsp.ack, mem_req.cyc, mem_req.stb, miss});
        test_errors++;
      end
    end
    $display("test 1: %s", (test_errors == 0) ? "ok" : "FAILED");
    tests_run++;
    if (test_errors != 0) tests_failed++;
    errors      = errors + test_errors;
    test_errors = 0;

    for (int k = 0; k < NUM_STIM && !timed_out; k++) begin
      s           = STIM_TABLE[k];
      reqs_before = mem_reqs;
      run_fetch(s, acked, cycles, misses, rdata);
      if (!acked) begin
        $display("timeout: no fetch ack for address %h after %0d cycles", s.adr, cycles);
        test_errors++;
        timed_out = 1'b1;
      end else begin
        new_reqs = mem_reqs - reqs_before;
        exp_word = word_at({s.adr[31:2], 2'b00});
        // disabled or bit 31 set never counts as a miss
        exp_miss = (new_reqs != 0) && s.en && !s.adr[NC_BIT];
        // line address for a cacheable refill, word address otherwise
        exp_adr  = (s.en && !s.adr[NC_BIT]) ? {s.adr[31:4], 4'h0} : {s.adr[31:2], 2'b00};
        if (rdata !== exp_word) begin
          $display("MISMATCH fetch_rsp_o.dat at %h: got %h expected %h", s.adr, rdata, exp_word);
          test_errors++;
        end
        if ((s.mem == MEM_YES && new_reqs != 1) || (s.mem == MEM_NO && new_reqs != 0)) begin
          $display("MISMATCH mem_req_o count at %h: got %h expected %h",
                   s.adr, new_reqs, (s.mem == MEM_YES) ? 1 : 0);
          test_errors++;
        end
        if (new_reqs > 1) begin
          $display("more than one memory request for the fetch at %h", s.adr);
          test_errors++;
        end
        if (new_reqs == 1 && mem_adr_seen !== exp_adr) begin
          $display("MISMATCH mem_req_o.adr at %h: got %h expected %h",
                   s.adr, mem_adr_seen, exp_adr);
          test_errors++;
        end
        // a hit acks in the second stb cycle
        if (s.mem == MEM_NO && cycles != 2) begin
          $display("MISMATCH fetch_rsp_o.ack latency at %h: got %h expected %h", s.adr, cycles, 2);
          test_errors++;
        end
        if (misses != (exp_miss ? 1 : 0)) begin
          $display("MISMATCH miss_o pulses at %h: got %h expected %h",
                   s.adr, misses, exp_miss ? 1 : 0);
          test_errors++;
        end
        if (new_reqs == 0) test_hits++;
      end
      if (timed_out || k == NUM_STIM - 1 || STIM_TABLE[k+1].test != s.test) begin
        // two ways cannot keep three lines
        if (s.test == 4'd5 && test_hits > 1) begin
          $display("set conflict: %0d re-fetches hit, at most one allowed", test_hits);
          test_errors++;
        end
        $display("test %0d: %s", s.test, (test_errors == 0) ? "ok" : "FAILED");
        tests_run++;
        if (test_errors != 0) tests_failed++;
        errors      = errors + test_errors;
        test_errors = 0;
        test_hits   = 0;
      end
    end

    $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
